// ==== verilog/tag_pkg.sv ====
package tag_pkg;

    // lanes carried by one stream beat
    localparam int word_width = 4;
    // tag time resolution matches the acquisition front end
    localparam int time_width = 64;
    // channel is signed, positive for rising edges and negative for falling edges
    localparam int channel_width = 6;

    // forward half of a stream beat, tready travels back as a plain bit
    typedef struct packed {
        logic                                      tvalid;
        logic [word_width-1:0][time_width-1:0]     tagtime;
        // element selects of a packed array are unsigned, so users apply $signed
        logic [word_width-1:0][channel_width-1:0]  channel;
        logic [word_width-1:0]                     tkeep;
        // no tag older than this can still arrive, even when tkeep is zero
        logic [time_width-1:0]                     lowest_time_bound;
    } tag_beat_t;

    // a single event as it sits in the capture FIFO
    typedef struct packed {
        logic [time_width-1:0]    tagtime;
        logic [channel_width-1:0] channel;
    } tag_event_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // capture buffer waits for a beat, then hands its lanes out one per cycle
    typedef enum logic {
        cap_idle,
        cap_split
    } capture_state_t;

    // register map, byte offsets on the APB
    localparam logic [11:0] reg_ctrl        = 12'h000;
    localparam logic [11:0] reg_status      = 12'h004;
    localparam logic [11:0] reg_buf_time_lo = 12'h008;
    localparam logic [11:0] reg_buf_time_hi = 12'h00C;
    localparam logic [11:0] reg_buf_channel = 12'h010;
    localparam logic [11:0] reg_buf_pop     = 12'h014;
    localparam logic [11:0] reg_ltb_lo      = 12'h018;
    localparam logic [11:0] reg_ltb_hi      = 12'h01C;
    // one word per channel starting here, channel 1 first
    localparam logic [11:0] reg_count_base  = 12'h040;

endpackage

// ==== verilog/tag_broadcast.sv ====
`timescale 1ns/1ps

module tag_broadcast #(
    parameter int fanout = 2
) (
    input  logic                                  s_axis,
    input  logic                                  rst,
    input  tag_pkg::tag_beat_t                    tag_in,
    output logic                                  tag_in_ready,
    output tag_pkg::tag_beat_t [fanout-1:0]       tag_out,
    input  logic [fanout-1:0]                     tag_out_ready
);

    // one bit per consumer, set once that consumer has taken the current beat
    logic [fanout-1:0] consumed;
    // consumers that take the beat in this very cycle
    logic [fanout-1:0] taken;
    logic              accept;

    // upstream may advance once nobody still needs the beat
    assign tag_in_ready = &(consumed | tag_out_ready);
    assign accept = tag_in.tvalid & tag_in_ready;

    always_comb begin
        for (int i = 0; i < fanout; i++) begin
            // the payload is shared, only the valid flag differs per consumer
            tag_out[i] = tag_in;
            // a consumer that already has the beat must not see it a second time
            tag_out[i].tvalid = tag_in.tvalid & ~consumed[i];
            taken[i] = tag_out[i].tvalid & tag_out_ready[i];
        end
    end

    // only a real handshake marks a consumer as done
    // a consumer that is merely ready while tvalid is low must still see the next beat
    always_ff @(posedge s_axis) begin
        if (rst) begin
            consumed <= '0;
        end else if (accept) begin
            // the beat leaves, so every consumer starts fresh on the next one
            consumed <= '0;
        end else begin
            consumed <= consumed | taken;
        end
    end

endmodule

// ==== verilog/tag_channel_counter.sv ====
`timescale 1ns/1ps

module tag_channel_counter #(
    parameter int num_channels = 8
) (
    input  logic                                s_axis,
    input  logic                                rst,
    input  tag_pkg::tag_beat_t                  tag_in,
    output logic                                tag_in_ready,
    input  logic                                clear,
    output logic [num_channels-1:0][31:0]       counts,
    output logic [tag_pkg::time_width-1:0]      lowest_time_bound
);

    // wide enough for every lane of one beat hitting the same channel
    localparam int inc_width = $clog2(tag_pkg::word_width + 1);

    logic                                   ready_q;
    logic                                   accept;
    logic [num_channels-1:0][inc_width-1:0] incr;

    // the counter never stalls, ready only drops while in reset
    assign tag_in_ready = ready_q;
    assign accept = tag_in.tvalid & ready_q;

    // per channel, count the kept lanes that carry its rising edge
    always_comb begin
        for (int c = 0; c < num_channels; c++) begin
            incr[c] = '0;
            for (int lane = 0; lane < tag_pkg::word_width; lane++) begin
                // falling edges are negative and never equal a channel number here
                // zero and channels past num_channels find no counter either
                if (tag_in.tkeep[lane] && ($signed(tag_in.channel[lane]) == c + 1)) begin
                    incr[c] = incr[c] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge s_axis) begin
        if (rst) begin
            ready_q           <= 1'b0;
            counts            <= '0;
            lowest_time_bound <= '0;
        end else begin
            ready_q <= 1'b1;
            // a clear in the same cycle as a beat drops that beat's events
            if (clear) begin
                counts <= '0;
            end else if (accept) begin
                for (int c = 0; c < num_channels; c++) begin
                    counts[c] <= counts[c] + 32'(incr[c]);
                end
            end
            // the bound follows every beat, empty beats included
            if (accept) begin
                lowest_time_bound <= tag_in.lowest_time_bound;
            end
        end
    end

endmodule

// ==== verilog/tag_capture_buffer.sv ====
`timescale 1ns/1ps

module tag_capture_buffer #(
    parameter int fifo_depth = 8
) (
    input  logic                s_axis,
    input  logic                rst,
    input  tag_pkg::tag_beat_t  tag_in,
    output logic                tag_in_ready,
    input  logic                pop,
    output tag_pkg::tag_event_t head,
    output logic [7:0]          level
);

    localparam int ptr_width  = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int lane_width = $clog2(tag_pkg::word_width);

    tag_pkg::capture_state_t state;
    logic                    active;
    logic                    accept;

    // copy of the beat being split, lanes are consumed from remaining
    logic [tag_pkg::word_width-1:0][tag_pkg::time_width-1:0]    beat_time;
    logic [tag_pkg::word_width-1:0][tag_pkg::channel_width-1:0] beat_channel;
    logic [tag_pkg::word_width-1:0]                             remaining;
    logic [tag_pkg::word_width-1:0]                             lane_mask;
    logic [lane_width-1:0]                                      lane;

    tag_pkg::tag_event_t mem [fifo_depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [7:0]           count;
    logic                 full;
    logic                 push;
    logic                 do_pop;

    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] p);
        // wrap by compare so depths that are not a power of two work as well
        if (p == ptr_width'(fifo_depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // active keeps ready low through reset without gating the output by rst
    assign tag_in_ready = active & (state == tag_pkg::cap_idle);
    assign accept = tag_in.tvalid & tag_in_ready;

    // lowest remaining lane goes first, so events leave in ascending lane order
    always_comb begin
        lane = '0;
        for (int i = tag_pkg::word_width - 1; i >= 0; i--) begin
            if (remaining[i]) begin
                lane = lane_width'(i);
            end
        end
        lane_mask = tag_pkg::word_width'(1) << lane;
    end

    assign full   = (count == fifo_depth);
    assign push   = (state == tag_pkg::cap_split) & ~full;
    // popping an empty FIFO is ignored
    assign do_pop = pop & (count != 8'd0);

    always_ff @(posedge s_axis) begin
        if (rst) begin
            state  <= tag_pkg::cap_idle;
            active <= 1'b0;
        end else begin
            active <= 1'b1;
            case (state)
                tag_pkg::cap_idle: begin
                    // an empty keep mask only carries the time bound, nothing to queue
                    if (accept && (tag_in.tkeep != '0)) begin
                        state <= tag_pkg::cap_split;
                    end
                end
                tag_pkg::cap_split: begin
                    // a full FIFO holds us here, which backs up the whole stream
                    if (push && ((remaining & ~lane_mask) == '0)) begin
                        state <= tag_pkg::cap_idle;
                    end
                end
                default: state <= tag_pkg::cap_idle;
            endcase
        end
    end

    always_ff @(posedge s_axis) begin
        if (accept) begin
            beat_time    <= tag_in.tagtime;
            beat_channel <= tag_in.channel;
            remaining    <= tag_in.tkeep;
        end else if (push) begin
            remaining <= remaining & ~lane_mask;
        end
    end

    always_ff @(posedge s_axis) begin
        if (push) begin
            mem[wr_ptr] <= '{tagtime: beat_time[lane], channel: beat_channel[lane]};
        end
    end

    always_ff @(posedge s_axis) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // push and pop together leave the level unchanged
            count <= count + {7'd0, push} - {7'd0, do_pop};
        end
    end

    assign head  = mem[rd_ptr];
    assign level = count;

endmodule

// ==== verilog/tag_apb_regs.sv ====
`timescale 1ns/1ps

module tag_apb_regs #(
    parameter int num_channels = 8
) (
    input  logic                            s_axis,
    input  logic                            rst,
    input  tag_pkg::apb_req_t               apb_req,
    output tag_pkg::apb_rsp_t               apb_rsp,
    output logic                            clear,
    output logic                            pop,
    input  logic [num_channels-1:0][31:0]   counts,
    input  logic [tag_pkg::time_width-1:0]  lowest_time_bound,
    input  tag_pkg::tag_event_t             head,
    input  logic [7:0]                      level
);

    // word index of the first count register
    localparam logic [9:0] count_word = tag_pkg::reg_count_base[11:2];

    logic        setup_q;
    logic        phase;
    logic        err;
    logic        ok;
    logic [11:0] addr;
    logic [9:0]  cnt_index;
    logic        cnt_hit;
    logic        buf_empty;
    logic        mapped;
    logic        read_only;
    logic        buf_reg;
    logic [31:0] rdata;

    // remember the setup phase so an access phase without one is rejected
    always_ff @(posedge s_axis) begin
        if (rst) begin
            setup_q <= 1'b0;
        end else begin
            setup_q <= apb_req.psel & ~apb_req.penable;
        end
    end

    assign addr      = apb_req.paddr;
    assign phase     = apb_req.psel & apb_req.penable;
    assign buf_empty = (level == 8'd0);

    // count registers sit on word boundaries from the base, one per channel
    assign cnt_index = addr[11:2] - count_word;
    assign cnt_hit   = (addr >= tag_pkg::reg_count_base) && (addr[1:0] == 2'b00) &&
                       (cnt_index < num_channels);

    always_comb begin
        rdata     = '0;
        mapped    = 1'b1;
        read_only = 1'b1;
        buf_reg   = 1'b0;
        case (addr)
            // control and pop are write strobes and read back as zero
            tag_pkg::reg_ctrl: begin
                read_only = 1'b0;
            end
            tag_pkg::reg_buf_pop: begin
                read_only = 1'b0;
            end
            tag_pkg::reg_status: begin
                rdata = {24'd0, level};
            end
            tag_pkg::reg_buf_time_lo: begin
                rdata   = head.tagtime[31:0];
                buf_reg = 1'b1;
            end
            tag_pkg::reg_buf_time_hi: begin
                rdata   = head.tagtime[63:32];
                buf_reg = 1'b1;
            end
            tag_pkg::reg_buf_channel: begin
                // raw two's complement bits, software sign extends if it cares
                rdata   = {26'd0, head.channel};
                buf_reg = 1'b1;
            end
            tag_pkg::reg_ltb_lo: begin
                rdata = lowest_time_bound[31:0];
            end
            tag_pkg::reg_ltb_hi: begin
                rdata = lowest_time_bound[63:32];
            end
            default: begin
                if (cnt_hit) begin
                    rdata = counts[cnt_index];
                end else begin
                    mapped = 1'b0;
                end
            end
        endcase
    end

    // the head of an empty FIFO holds stale data, so reading it is an error
    assign err = phase & (~setup_q | ~mapped | (~apb_req.pwrite & buf_reg & buf_empty) |
                          (apb_req.pwrite & read_only));
    assign ok  = phase & setup_q & ~err;

    // strobes last exactly the access phase, no wait states are inserted
    assign clear = ok & apb_req.pwrite & (addr == tag_pkg::reg_ctrl) & apb_req.pwdata[0];
    // a pop write on an empty FIFO completes but does nothing
    assign pop   = ok & apb_req.pwrite & (addr == tag_pkg::reg_buf_pop) & ~buf_empty;

    assign apb_rsp = '{prdata: rdata, pready: phase, pslverr: err};

endmodule

// ==== verilog/tag_stream_top.sv ====
`timescale 1ns/1ps

module tag_stream_top #(
    parameter int num_channels = 8,
    parameter int fifo_depth   = 8
) (
    input  logic               s_axis,
    input  logic               rst,
    input  tag_pkg::tag_beat_t tag_in,
    output logic               tag_in_ready,
    input  tag_pkg::apb_req_t  apb_req,
    output tag_pkg::apb_rsp_t  apb_rsp
);

    // consumer 0 is the counter, consumer 1 the capture buffer
    tag_pkg::tag_beat_t [1:0]               bc_beat;
    logic [1:0]                             bc_ready;

    logic [num_channels-1:0][31:0]          counts;
    logic [tag_pkg::time_width-1:0]         lowest_time_bound;
    tag_pkg::tag_event_t                    head;
    logic [7:0]                             level;
    logic                                   clear;
    logic                                   pop;

    // a full capture FIFO stalls the input through here as well
    tag_broadcast #(
        .fanout(2)
    ) u_broadcast (
        .s_axis       (s_axis),
        .rst          (rst),
        .tag_in       (tag_in),
        .tag_in_ready (tag_in_ready),
        .tag_out      (bc_beat),
        .tag_out_ready(bc_ready)
    );

    tag_channel_counter #(
        .num_channels(num_channels)
    ) u_counter (
        .s_axis           (s_axis),
        .rst              (rst),
        .tag_in           (bc_beat[0]),
        .tag_in_ready     (bc_ready[0]),
        .clear            (clear),
        .counts           (counts),
        .lowest_time_bound(lowest_time_bound)
    );

    tag_capture_buffer #(
        .fifo_depth(fifo_depth)
    ) u_capture (
        .s_axis      (s_axis),
        .rst         (rst),
        .tag_in      (bc_beat[1]),
        .tag_in_ready(bc_ready[1]),
        .pop         (pop),
        .head        (head),
        .level       (level)
    );

    // software side, reads both consumers and drives their control strobes
    tag_apb_regs #(
        .num_channels(num_channels)
    ) u_regs (
        .s_axis           (s_axis),
        .rst              (rst),
        .apb_req          (apb_req),
        .apb_rsp          (apb_rsp),
        .clear            (clear),
        .pop              (pop),
        .counts           (counts),
        .lowest_time_bound(lowest_time_bound),
        .head             (head),
        .level            (level)
    );

endmodule

// ==== include/tb_tag_vectors.svh ====
`ifndef TB_TAG_VECTORS_SVH
`define TB_TAG_VECTORS_SVH

// stimulus table, each column holds one entry per beat
// vec_time is the lane 0 tag time and lane i of the beat carries vec_time plus i
// vec_chan lists lanes 0 to 3, negative channels are falling edges
// vec_keep has lane 0 in bit 0, vec_ltb is the lowest time bound sent with the beat
localparam int num_beats = 12;

// beat 5 starts just below a 32-bit boundary so its lanes carry into the high half
localparam logic [63:0] vec_time [num_beats] = '{
    64'h0000_0001_0000_0100, 64'h0000_0001_0000_0200, 64'h0000_0001_8000_0300,
    64'h0000_0002_0000_0400, 64'h0000_0002_0000_0500, 64'h0000_0002_ffff_fffe,
    64'h0000_0003_0000_0700, 64'h0000_0003_1234_0800, 64'h0000_0004_0000_0900,
    64'h0000_0004_0000_0a00, 64'h0000_0005_0000_0b00, 64'h0000_0005_abcd_0c00
};

// zero, negative and out-of-range channels are mixed in with rising edges 1 to 8
localparam logic signed [5:0] vec_chan [num_beats][4] = '{
    '{6'sd1, 6'sd2, 6'sd3, 6'sd4},
    '{6'sd5, 6'sd6, 6'sd7, 6'sd8},
    '{6'sd1, -6'sd1, 6'sd0, 6'sd9},
    '{6'sd2, 6'sd2, -6'sd3, 6'sd31},
    '{6'sd3, 6'sd4, 6'sd5, 6'sd6},
    '{6'sd8, -6'sd8, 6'sd12, 6'sd1},
    '{6'sd7, 6'sd7, 6'sd7, 6'sd7},
    '{-6'sd31, 6'sd0, 6'sd6, 6'sd2},
    '{6'sd4, 6'sd3, 6'sd2, 6'sd1},
    '{6'sd5, -6'sd5, 6'sd20, 6'sd8},
    '{6'sd1, 6'sd1, 6'sd1, 6'sd1},
    '{6'sd6, 6'sd3, -6'sd2, 6'sd4}
};

// beats 4 and 10 carry only their time bound
localparam logic [3:0] vec_keep [num_beats] = '{
    4'b1111, 4'b1111, 4'b1111, 4'b0101, 4'b0000, 4'b1011,
    4'b1111, 4'b1100, 4'b1000, 4'b0111, 4'b0000, 4'b1101
};

localparam logic [63:0] vec_ltb [num_beats] = '{
    64'h0000_0001_0000_0000, 64'h0000_0001_0000_0180, 64'h0000_0001_7fff_0000,
    64'h0000_0002_0000_0000, 64'h0000_0002_0000_0480, 64'h0000_0002_ffff_0000,
    64'h0000_0003_0000_0000, 64'h0000_0003_1234_0000, 64'h0000_0004_0000_0000,
    64'h0000_0004_0000_0980, 64'h0000_0005_0000_0000, 64'h0000_0005_abcd_0b80
};

// addresses outside the register map, 0x060 is the word after the last count
localparam logic [11:0] unmapped_addr [4] = '{12'h020, 12'h03c, 12'h060, 12'h042};

`endif

// ==== verification/tb_tag_stream.sv ====
`timescale 1ns/1ps

module tb_tag_stream;

    localparam int num_channels = 8;
    localparam int fifo_depth   = 8;
    // upper bound for any single wait, counted in cycles or in polls
    localparam int wait_limit   = 1000;
    // cycles over which a full FIFO must keep the stream stalled
    localparam int stall_window = 16;

    `include "tb_tag_vectors.svh"

    logic               s_axis;
    logic               rst;
    tag_pkg::tag_beat_t tag_in;
    logic               tag_in_ready;
    tag_pkg::apb_req_t  apb_req;
    tag_pkg::apb_rsp_t  apb_rsp;

    // expected FIFO contents in order, and expected count per channel
    tag_pkg::tag_event_t exp_events [$];
    int                  exp_count [num_channels];

    tag_stream_top #(
        .num_channels(num_channels),
        .fifo_depth  (fifo_depth)
    ) u_tag_stream_top (
        .s_axis      (s_axis),
        .rst         (rst),
        .tag_in      (tag_in),
        .tag_in_ready(tag_in_ready),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp)
    );

    initial begin
        s_axis = 1'b0;
        forever #2 s_axis = ~s_axis;
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("[ERROR] %s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    // kept lanes go to the FIFO in ascending lane order and rising edges 1..8 are counted
    task automatic build_expected();
        tag_pkg::tag_event_t ev;
        int ch;
        for (int c = 0; c < num_channels; c++) begin
            exp_count[c] = 0;
        end
        for (int b = 0; b < num_beats; b++) begin
            for (int i = 0; i < tag_pkg::word_width; i++) begin
                if (vec_keep[b][i]) begin
                    ev.tagtime = vec_time[b] + 64'(i);
                    ev.channel = vec_chan[b][i];
                    exp_events.push_back(ev);
                    ch = vec_chan[b][i];
                    if (ch >= 1 && ch <= num_channels) begin
                        exp_count[ch-1]++;
                    end
                end
            end
        end
    endtask

    // one setup phase and one access phase with the response sampled mid-cycle
    // the slave has no wait states, so pready must already be high in the access phase
    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr);
        @(posedge s_axis);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge s_axis);
        apb_req <= '{psel: 1'b1, penable: 1'b1, pwrite: write, paddr: addr, pwdata: wdata};
        @(negedge s_axis);
        assert (apb_rsp.pready === 1'b1) else
            report_mismatch("pready", apb_rsp.pready, 1);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(posedge s_axis);
        apb_req <= '0;
    endtask

    task automatic read_check(input logic [11:0] addr, input logic [31:0] exp,
                              input string name);
        logic [31:0] rdata;
        logic        slverr;
        apb_access(1'b0, addr, 32'd0, rdata, slverr);
        assert (slverr == 1'b0) else report_mismatch({name, " pslverr"}, slverr, 0);
        assert (rdata == exp) else report_mismatch(name, rdata, exp);
    endtask

    task automatic write_check(input logic [11:0] addr, input logic [31:0] data,
                               input string name);
        logic [31:0] rdata;
        logic        slverr;
        apb_access(1'b1, addr, data, rdata, slverr);
        assert (slverr == 1'b0) else report_mismatch({name, " pslverr"}, slverr, 0);
    endtask

    task automatic slverr_check(input logic write, input logic [11:0] addr, input logic exp);
        logic [31:0] rdata;
        logic        slverr;
        apb_access(write, addr, 32'd0, rdata, slverr);
        assert (slverr == exp) else
            report_mismatch($sformatf("pslverr at 0x%03h", addr), slverr, exp);
    endtask

    // polls reg_status until the level satisfies the request
    task automatic wait_level(input bit want_full, input string what);
        logic [31:0] rdata;
        logic        slverr;
        int          polls;
        polls = 0;
        rdata = '0;
        while (want_full ? (rdata[7:0] != fifo_depth) : (rdata[7:0] == 8'd0)) begin
            polls++;
            assert (polls < wait_limit) else report_failure(what);
            apb_access(1'b0, tag_pkg::reg_status, 32'd0, rdata, slverr);
            assert (rdata[7:0] <= fifo_depth) else
                report_mismatch("status level", rdata[7:0], fifo_depth);
        end
    endtask

    // drives one table row and holds it until the handshake edge
    task automatic send_beat(input int b);
        tag_pkg::tag_beat_t beat;
        int                 waited;
        beat.tvalid = 1'b1;
        for (int i = 0; i < tag_pkg::word_width; i++) begin
            beat.tagtime[i] = vec_time[b] + 64'(i);
            beat.channel[i] = vec_chan[b][i];
        end
        beat.tkeep             = vec_keep[b];
        beat.lowest_time_bound = vec_ltb[b];
        waited = 0;
        tag_in <= beat;
        @(negedge s_axis);
        while (tag_in_ready !== 1'b1) begin
            waited++;
            assert (waited < wait_limit) else report_failure("tag_in_ready stuck low");
            @(negedge s_axis);
        end
        @(posedge s_axis);
    endtask

    task automatic run_driver();
        for (int b = 0; b < num_beats; b++) begin
            send_beat(b);
        end
        tag_in <= '0;
    endtask

    // with the FIFO full and nothing popped, the stream must stay blocked
    task automatic check_stall();
        int waited;
        waited = 0;
        @(negedge s_axis);
        // a beat already in flight when the FIFO filled may still be accepted
        while (tag_in_ready !== 1'b0) begin
            waited++;
            assert (waited < wait_limit) else report_failure("stream never stalled");
            @(negedge s_axis);
        end
        for (int i = 0; i < stall_window; i++) begin
            @(negedge s_axis);
            assert (tag_in_ready == 1'b0) else report_mismatch("tag_in_ready", tag_in_ready, 0);
        end
    endtask

    task automatic run_drainer();
        tag_pkg::tag_event_t exp;
        wait_level(1'b1, "capture FIFO never filled");
        check_stall();
        while (exp_events.size() > 0) begin
            wait_level(1'b0, "capture FIFO stayed empty");
            exp = exp_events.pop_front();
            read_check(tag_pkg::reg_buf_time_lo, exp.tagtime[31:0], "buf_time_lo");
            read_check(tag_pkg::reg_buf_time_hi, exp.tagtime[63:32], "buf_time_hi");
            read_check(tag_pkg::reg_buf_channel, {26'd0, exp.channel}, "buf_channel");
            write_check(tag_pkg::reg_buf_pop, 32'd1, "buf_pop");
        end
    endtask

    initial begin
        rst     = 1'b1;
        tag_in  = '0;
        apb_req = '0;
        build_expected();
        for (int i = 0; i < 8; i++) begin
            @(negedge s_axis);
            assert (tag_in_ready === 1'b0) else
                report_mismatch("tag_in_ready in reset", tag_in_ready, 0);
        end
        @(posedge s_axis);
        rst <= 1'b0;
        fork
            run_driver();
            run_drainer();
        join
        // every event was read once, so nothing may be left behind
        read_check(tag_pkg::reg_status, 32'd0, "status level");
        slverr_check(1'b0, tag_pkg::reg_buf_time_lo, 1'b1);
        for (int c = 0; c < num_channels; c++) begin
            read_check(tag_pkg::reg_count_base + 12'(4 * c), exp_count[c],
                       $sformatf("count[%0d]", c + 1));
        end
        read_check(tag_pkg::reg_ltb_lo, vec_ltb[num_beats-1][31:0], "ltb_lo");
        read_check(tag_pkg::reg_ltb_hi, vec_ltb[num_beats-1][63:32], "ltb_hi");
        write_check(tag_pkg::reg_ctrl, 32'd1, "ctrl");
        for (int c = 0; c < num_channels; c++) begin
            read_check(tag_pkg::reg_count_base + 12'(4 * c), 32'd0,
                       $sformatf("cleared count[%0d]", c + 1));
        end
        for (int i = 0; i < 4; i++) begin
            slverr_check(1'b0, unmapped_addr[i], 1'b1);
            slverr_check(1'b1, unmapped_addr[i], 1'b1);
        end
        // status is read only
        slverr_check(1'b1, tag_pkg::reg_status, 1'b1);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+include
verilog/tag_pkg.sv
verilog/tag_broadcast.sv
verilog/tag_channel_counter.sv
verilog/tag_capture_buffer.sv
verilog/tag_apb_regs.sv
verilog/tag_stream_top.sv
verification/tb_tag_stream.sv
